// ==== Makefile ====
TOP = tb_vicii

.PHONY: compile run clean

compile:
	verilator --binary --assert --top-module $(TOP) -f vicii_core.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== common/phase_if.sv ====
`timescale 1ns/1ps

// phase timing from the generator to every block that works off clk_phi
interface phase_if import vicii_pkg::*; ();
   // processor phase clock
   logic       clk_phi;
   // bit k high on tick k of the current phase
   phase_vec_t phi_start;
   // high on the tick before a dot edge
   logic       dot_rise;
   // 0..15 while phi is low, 16..31 while phi is high
   fine_ctr_t  fine_ctr;
   // cpu owns the bus while high
   logic       aec;

   modport gen(output clk_phi, phi_start, dot_rise, fine_ctr, aec);
   modport sink(input clk_phi, phi_start, dot_rise, fine_ctr, aec);
endinterface

// raster interrupt control between the register file and the irq block
interface irq_if import vicii_pkg::*; ();
   // line to compare against, $11 bit 7 and $12
   raster_line_t raster_cmp;
   // raster irq enable, $1a bit 0
   logic         erst;
   // single tick clear of the latch
   logic         irst_clr;
   // latched raster condition, reported even when masked
   logic         irst;

   modport regs(output raster_cmp, erst, irst_clr, input irst);
   modport irq(input raster_cmp, erst, irst_clr, output irst);
endinterface

// ==== common/vicii_pkg.sv ====
// shared types, register map and chip limits for the timing core
package vicii_pkg;

   // chip selection, the unused code runs as a 6569
   typedef enum logic [1:0] {
      CHIP6567R8   = 2'd0,
      CHIP6567R56A = 2'd1,
      CHIP6569     = 2'd2,
      CHIPUNUSED   = 2'd3
   } chip_t;

   // beam position and cpu bus widths
   typedef logic [9:0]  raster_x_t;
   typedef logic [8:0]  raster_line_t;
   typedef logic [5:0]  reg_addr_t;
   typedef logic [7:0]  reg_data_t;
   // one-hot tick within the current phi phase
   typedef logic [15:0] phase_vec_t;
   // tick within a full phi period (32 ticks)
   typedef logic [4:0]  fine_ctr_t;

   // raster related registers
   localparam reg_addr_t REG_CTRL1  = 6'h11;
   localparam reg_addr_t REG_RASTER = 6'h12;
   localparam reg_addr_t REG_IRQ    = 6'h19;
   localparam reg_addr_t REG_IRQ_EN = 6'h1a;

   // last pixel of a line, 520 / 512 / 504 pixels per line
   function automatic raster_x_t chip_raster_x_max(chip_t chip);
      case (chip)
         CHIP6567R8:   return 10'd519;
         CHIP6567R56A: return 10'd511;
         default:      return 10'd503;
      endcase
   endfunction

   // last line of a frame, 263 / 262 / 312 lines
   function automatic raster_line_t chip_raster_y_max(chip_t chip);
      case (chip)
         CHIP6567R8:   return 9'd262;
         CHIP6567R56A: return 9'd261;
         default:      return 9'd311;
      endcase
   endfunction

endpackage

// ==== hw/phase_gen.sv ====
`timescale 1ns/1ps

// phase clock, phase strobes, dot strobe and bus ownership
module phase_gen import vicii_pkg::*; (
   input  logic clk_dot4x,
   input  logic rst,
   phase_if.gen ph
);

   // rotating phi waveform, bit 0 is the current phi level
   logic [31:0] phi_gen;
   // rotating phase-start marker, realigned each phase by the rotation
   phase_vec_t  phi_phase;
   // rotating dot marker, one set bit every 4 ticks
   logic [3:0]  dot_gen;
   fine_ctr_t   fine_ctr;
   logic        aec;

   // reset leaves phi low with 12 more low ticks before the first high phase
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_gen <= 32'b0000_0000_0000_1111_1111_1111_1111_0000;
      end else begin
         phi_gen <= {phi_gen[30:0], phi_gen[31]};
      end
   end

   // bit 0 lines up with the first tick of every phase
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_phase <= 16'b0000_0000_0000_1000;
      end else begin
         phi_phase <= {phi_phase[14:0], phi_phase[15]};
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         dot_gen <= 4'b1000;
      end else begin
         dot_gen <= {dot_gen[2:0], dot_gen[3]};
      end
   end

   // starts at 3 so that 16 falls on the phi rising tick
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         fine_ctr <= 5'd3;
      end else begin
         fine_ctr <= fine_ctr + 5'd1;
      end
   end

   // no stolen cycles, the cpu gets every phi high phase one tick late
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         aec <= 1'b0;
      end else begin
         aec <= phi_gen[0];
      end
   end

   assign ph.clk_phi   = phi_gen[0];
   assign ph.phi_start = phi_phase;
   assign ph.dot_rise  = dot_gen[0];
   assign ph.fine_ctr  = fine_ctr;
   assign ph.aec       = aec;

endmodule

// ==== hw/raster_counter.sv ====
`timescale 1ns/1ps

// beam position counters, wrap points depend on the chip
module raster_counter import vicii_pkg::*; (
   input  logic         clk_dot4x,
   input  logic         rst,
   phase_if.sink        ph,
   input  chip_t        chip,
   output raster_x_t    raster_x,
   output raster_line_t raster_line,
   output raster_line_t raster_line_d
);

   // limits of the selected chip
   raster_x_t    x_max;
   raster_line_t y_max;
   logic         line_end;
   logic         frame_end;

   assign x_max = chip_raster_x_max(chip);
   assign y_max = chip_raster_y_max(chip);

   // last pixel of the line and last line of the frame
   assign line_end  = (raster_x == x_max);
   assign frame_end = (raster_line == y_max);

   // one pixel per dot
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x <= '0;
      end else if (ph.dot_rise) begin
         if (line_end) begin
            raster_x <= '0;
         end else begin
            raster_x <= raster_x + 10'd1;
         end
      end
   end

   // line steps on the same dot that x wraps
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_line <= '0;
      end else if (ph.dot_rise && line_end) begin
         if (frame_end) begin
            raster_line <= '0;
         end else begin
            raster_line <= raster_line + 9'd1;
         end
      end
   end

   // line as seen by the cpu and the compare, lags by up to one phi period
   // sampled on the first tick of the phi high phase
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_line_d <= '0;
      end else if (ph.clk_phi && ph.phi_start[0]) begin
         raster_line_d <= raster_line;
      end
   end

endmodule

// ==== hw/raster_irq.sv ====
`timescale 1ns/1ps

// raster compare and interrupt latch
module raster_irq import vicii_pkg::*; (
   input  logic         clk_dot4x,
   input  logic         rst,
   phase_if.sink        ph,
   input  raster_line_t raster_line_d,
   irq_if.irq           ir,
   output logic         irq
);

   // compare point, tick 1 of the phi high phase
   logic cmp_tick;
   // already fired on this line
   logic triggered;
   logic irst;

   assign cmp_tick = ph.clk_phi && ph.phi_start[1];

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         triggered <= 1'b0;
         irst      <= 1'b0;
      end else begin
         if (cmp_tick) begin
            if (raster_line_d == ir.raster_cmp) begin
               // only the first matching phase of a line sets the latch
               if (!triggered) begin
                  triggered <= 1'b1;
                  irst      <= 1'b1;
               end
            end else begin
               // line moved on, arm for the next match
               triggered <= 1'b0;
            end
         end
         // cpu clear wins over a set in the same tick
         if (ir.irst_clr) begin
            irst <= 1'b0;
         end
      end
   end

   // condition is latched even while masked, so enabling erst
   // later raises irq straight away
   assign ir.irst = irst;
   assign irq     = irst & ir.erst;

endmodule

// ==== hw/registers.sv ====
`timescale 1ns/1ps

// cpu register window for the raster registers and data bus direction
module registers import vicii_pkg::*; #(
   // tick of the phi high phase at which write data is taken
   parameter int unsigned REG_DAV            = 13,
   // last fine tick at which the chip may drive the data bus
   parameter int unsigned DB_WRITE_LAST_TICK = 23
) (
   input  logic         clk_dot4x,
   input  logic         rst,
   phase_if.sink        ph,
   input  logic         ce,
   input  logic         rw,
   input  reg_addr_t    adi,
   input  reg_data_t    dbi,
   input  raster_line_t raster_line_d,
   input  logic         irq,
   irq_if.regs          ir,
   output reg_data_t    dbo,
   output logic         ls245_dir,
   output logic         vic_write_db
);

   logic         wr_strobe;
   logic         rd_strobe;
   reg_data_t    rd_data;
   raster_line_t raster_cmp;
   logic         erst;
   logic         irst_clr;

   // cpu write, data is stable by REG_DAV of the high phase
   assign wr_strobe = ph.clk_phi && ph.phi_start[REG_DAV] && !ce && !rw;
   // cpu read, result goes out on the last tick of the high phase
   assign rd_strobe = ph.clk_phi && ph.phi_start[15] && !ce && rw;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_cmp <= '0;
         erst       <= 1'b0;
         irst_clr   <= 1'b0;
      end else begin
         // clear is a single tick pulse
         irst_clr <= 1'b0;
         if (wr_strobe) begin
            case (adi)
               // only bit 7 of $11 exists here, compare bit 8
               REG_CTRL1:  raster_cmp[8]   <= dbi[7];
               REG_RASTER: raster_cmp[7:0] <= dbi;
               // writing 1 acknowledges the raster irq
               REG_IRQ:    irst_clr        <= dbi[0];
               REG_IRQ_EN: erst            <= dbi[0];
               default:    ;
            endcase
         end
      end
   end

   // read mux, unused bits read back as on the real chip
   always_comb begin
      case (adi)
         REG_CTRL1:  rd_data = {raster_line_d[8], 7'b000_0000};
         REG_RASTER: rd_data = raster_line_d[7:0];
         // other irq sources are absent and read 0
         REG_IRQ:    rd_data = {irq, 3'b111, 3'b000, ir.irst};
         REG_IRQ_EN: rd_data = {4'hf, 3'b000, erst};
         default:    rd_data = 8'hff;
      endcase
   end

   always_ff @(posedge clk_dot4x) begin
      if (rd_strobe) begin
         dbo <= rd_data;
      end
   end

   assign ir.raster_cmp = raster_cmp;
   assign ir.erst       = erst;
   assign ir.irst_clr   = irst_clr;

   // data transceiver direction
   // low drives the cpu bus, only during a cpu read of the chip
   assign ls245_dir = (ph.aec && !ce) ? !rw : 1'b1;

   // stop driving early enough to avoid contention at the phase end
   assign vic_write_db = ph.aec && rw && !ce
                         && (ph.fine_ctr <= fine_ctr_t'(DB_WRITE_LAST_TICK));

endmodule

// ==== hw/vicii_core.sv ====
`timescale 1ns/1ps

// timing core: phase generator, beam counters, raster irq, registers
module vicii_core import vicii_pkg::*; #(
   parameter int unsigned REG_DAV            = 13,
   parameter int unsigned DB_WRITE_LAST_TICK = 23
) (
   input  logic         clk_dot4x,
   input  logic         rst,
   input  chip_t        chip,
   input  logic         ce,
   input  logic         rw,
   input  reg_addr_t    adi,
   input  reg_data_t    dbi,
   output logic         clk_phi,
   output raster_x_t    raster_x,
   output raster_line_t raster_line,
   output reg_data_t    dbo,
   output logic         irq,
   output logic         aec,
   output logic         ls245_dir,
   output logic         vic_write_db
);

   phase_if      ph();
   irq_if        ir();
   // line copy taken at each phi high start
   raster_line_t raster_line_d;

   phase_gen i_phase_gen (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .ph        (ph.gen)
   );

   raster_counter i_raster_counter (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .ph            (ph.sink),
      .chip          (chip),
      .raster_x      (raster_x),
      .raster_line   (raster_line),
      .raster_line_d (raster_line_d)
   );

   raster_irq i_raster_irq (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .ph            (ph.sink),
      .raster_line_d (raster_line_d),
      .ir            (ir.irq),
      .irq           (irq)
   );

   registers #(
      .REG_DAV            (REG_DAV),
      .DB_WRITE_LAST_TICK (DB_WRITE_LAST_TICK)
   ) i_registers (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .ph            (ph.sink),
      .ce            (ce),
      .rw            (rw),
      .adi           (adi),
      .dbi           (dbi),
      .raster_line_d (raster_line_d),
      .irq           (irq),
      .ir            (ir.regs),
      .dbo           (dbo),
      .ls245_dir     (ls245_dir),
      .vic_write_db  (vic_write_db)
   );

   // phase clock and bus ownership go straight to the pins
   assign clk_phi = ph.clk_phi;
   assign aec     = ph.aec;

endmodule

// ==== testbench/tb_vicii.sv ====
`timescale 1ns/1ps

module tb_vicii import vicii_pkg::*; ();

   // table operations
   localparam int OP_RESET     = 0;
   localparam int OP_WRITE     = 1;
   localparam int OP_READ      = 2;
   localparam int OP_READ_LINE = 3;
   localparam int OP_WAIT_LINE = 4;
   localparam int OP_IRQ       = 5;

   logic         clk_dot4x;
   logic         rst;
   chip_t        chip;
   logic         ce;
   logic         rw;
   reg_addr_t    adi;
   reg_data_t    dbi;
   logic         clk_phi;
   raster_x_t    raster_x;
   raster_line_t raster_line;
   reg_data_t    dbo;
   logic         irq;
   logic         aec;
   logic         ls245_dir;
   logic         vic_write_db;
   logic [1:0]   chk_req;
   reg_data_t    chk_exp;
   int           chk_errors;
   int           timeouts;
   logic         table_ready;

   // stimulus table, one column per queue
   int           tbl_op[$];
   reg_addr_t    tbl_addr[$];
   logic [8:0]   tbl_data[$];
   reg_data_t    tbl_exp[$];

   vicii_core i_vicii_core (.*);

   vicii_checker i_vicii_checker (.*, .errors(chk_errors));

   bind vicii_core vicii_properties i_vicii_properties (
      .clk_dot4x    (clk_dot4x),
      .rst          (rst),
      .clk_phi      (clk_phi),
      .aec          (aec),
      .ce           (ce),
      .rw           (rw),
      .vic_write_db (vic_write_db)
   );

   initial clk_dot4x = 1'b0;
   always #4 clk_dot4x = ~clk_dot4x;

   task automatic add_entry(input int op, input reg_addr_t a, input logic [8:0] d,
                            input reg_data_t e);
      tbl_op.push_back(op);
      tbl_addr.push_back(a);
      tbl_data.push_back(d);
      tbl_exp.push_back(e);
   endtask

   // bus lines hold random values between cpu accesses
   task automatic idle_bus();
      logic [31:0] r;
      r   = $urandom();
      ce  = 1'b1;
      rw  = 1'b1;
      adi = r[5:0];
      dbi = r[15:8];
   endtask

   // one cpu access over a whole phi high phase
   task automatic bus_cycle(input logic is_read, input reg_addr_t a, input reg_data_t d);
      @(negedge clk_dot4x);
      while (clk_phi) @(negedge clk_dot4x);
      ce  = 1'b0;
      rw  = is_read;
      adi = a;
      dbi = d;
      while (!clk_phi) @(negedge clk_dot4x);
      while (clk_phi) @(negedge clk_dot4x);
      idle_bus();
   endtask

   task automatic request_check(input logic [1:0] kind, input reg_data_t e);
      chk_req = kind;
      chk_exp = e;
      @(negedge clk_dot4x);
      chk_req = 2'd0;
   endtask

   // phi periods in one frame, 8 dots per phi period
   function automatic longint frame_phi(input chip_t c);
      case (c)
         CHIP6567R8:   return longint'(520 * 263 / 8);
         CHIP6567R56A: return longint'(512 * 262 / 8);
         default:      return longint'(504 * 312 / 8);
      endcase
   endfunction

   initial begin
      void'($urandom(32'h810155fe));
      rst         = 1'b1;
      chip        = CHIP6567R8;
      chk_req     = 2'd0;
      chk_exp     = 8'h00;
      timeouts    = 0;
      table_ready = 1'b0;
      idle_bus();

      // enable register readback and unused address, NTSC chip
      add_entry(OP_RESET,     6'h00, 9'd0,  8'h00);
      add_entry(OP_WRITE,     6'h1a, 9'h01, 8'h00);
      add_entry(OP_READ,      6'h1a, 9'h00, 8'hf1);
      add_entry(OP_WRITE,     6'h1a, 9'h00, 8'h00);
      add_entry(OP_READ,      6'h1a, 9'h00, 8'hf0);
      add_entry(OP_READ_LINE, 6'h12, 9'h00, 8'h00);
      add_entry(OP_READ,      6'h3f, 9'h00, 8'hff);
      // raster irq on line 5, clear the line 0 match from reset
      add_entry(OP_WRITE,     6'h11, 9'h00, 8'h00);
      add_entry(OP_WRITE,     6'h12, 9'h05, 8'h00);
      add_entry(OP_WRITE,     6'h19, 9'h01, 8'h00);
      add_entry(OP_WRITE,     6'h1a, 9'h01, 8'h00);
      add_entry(OP_IRQ,       6'h00, 9'h00, 8'h00);
      // still low as line 5 begins, the compare sees it one phase later
      add_entry(OP_WAIT_LINE, 6'h00, 9'd5,  8'h00);
      add_entry(OP_IRQ,       6'h00, 9'h00, 8'h00);
      add_entry(OP_WAIT_LINE, 6'h00, 9'd6,  8'h00);
      add_entry(OP_IRQ,       6'h00, 9'h00, 8'h01);
      add_entry(OP_READ,      6'h19, 9'h00, 8'hf1);
      add_entry(OP_WRITE,     6'h19, 9'h01, 8'h00);
      add_entry(OP_IRQ,       6'h00, 9'h00, 8'h00);
      add_entry(OP_WAIT_LINE, 6'h00, 9'd7,  8'h00);
      add_entry(OP_IRQ,       6'h00, 9'h00, 8'h00);
      // masked irq on line 10, then enabled late
      add_entry(OP_WRITE,     6'h1a, 9'h00, 8'h00);
      add_entry(OP_WRITE,     6'h12, 9'h0a, 8'h00);
      add_entry(OP_WAIT_LINE, 6'h00, 9'd11, 8'h00);
      add_entry(OP_IRQ,       6'h00, 9'h00, 8'h00);
      add_entry(OP_READ,      6'h19, 9'h00, 8'h71);
      add_entry(OP_WRITE,     6'h1a, 9'h01, 8'h00);
      add_entry(OP_IRQ,       6'h00, 9'h00, 8'h01);
      add_entry(OP_WRITE,     6'h19, 9'h01, 8'h00);
      add_entry(OP_IRQ,       6'h00, 9'h00, 8'h00);
      // PAL chip, run through the frame wrap
      add_entry(OP_RESET,     6'h00, 9'd2,  8'h00);
      add_entry(OP_READ_LINE, 6'h12, 9'h00, 8'h00);
      add_entry(OP_READ,      6'h3f, 9'h00, 8'hff);
      add_entry(OP_WAIT_LINE, 6'h00, 9'd311, 8'h00);
      add_entry(OP_WAIT_LINE, 6'h00, 9'd0,  8'h00);
      add_entry(OP_READ_LINE, 6'h12, 9'h00, 8'h00);
      table_ready = 1'b1;

      foreach (tbl_op[i]) begin
         case (tbl_op[i])
            OP_RESET: begin
               @(negedge clk_dot4x);
               rst  = 1'b1;
               chip = chip_t'(tbl_data[i][1:0]);
               repeat (4) @(negedge clk_dot4x);
               rst = 1'b0;
            end
            OP_WRITE: bus_cycle(1'b0, tbl_addr[i], tbl_data[i][7:0]);
            OP_READ: begin
               bus_cycle(1'b1, tbl_addr[i], 8'h00);
               request_check(2'd1, tbl_exp[i]);
            end
            OP_READ_LINE: begin
               bus_cycle(1'b1, tbl_addr[i], 8'h00);
               request_check(2'd2, 8'h00);
            end
            OP_WAIT_LINE: begin
               @(negedge clk_dot4x);
               while (raster_line != tbl_data[i]) @(negedge clk_dot4x);
            end
            default: request_check(2'd3, tbl_exp[i]);
         endcase
      end
      repeat (4) @(negedge clk_dot4x);

      $display("errors: %0d check failures, %0d timeouts", chk_errors, timeouts);
      if (chk_errors == 0 && timeouts == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // limit from the worst case phi periods of every table entry
   initial begin
      longint total_phi;
      longint limit_ns;
      chip_t  wd_chip;
      total_phi = 0;
      wd_chip   = CHIP6567R8;
      wait (table_ready);
      foreach (tbl_op[i]) begin
         case (tbl_op[i])
            OP_RESET: begin
               wd_chip   = chip_t'(tbl_data[i][1:0]);
               total_phi = total_phi + 2;
            end
            OP_WAIT_LINE: total_phi = total_phi + frame_phi(wd_chip);
            OP_IRQ:       total_phi = total_phi + 1;
            default:      total_phi = total_phi + 3;
         endcase
      end
      // 32 ticks of 8 ns per phi period, 10% margin
      limit_ns = total_phi * 32 * 8 * 11 / 10;
      #(limit_ns);
      timeouts++;
      $display("timeout: the run did not finish within %0d ns", limit_ns);
      $display("errors: %0d check failures, %0d timeouts", chk_errors, timeouts);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== testbench/vicii_checker.sv ====
`timescale 1ns/1ps

// beam counter model and output comparisons
module vicii_checker import vicii_pkg::*; (
   input  logic         clk_dot4x,
   input  logic         rst,
   input  chip_t        chip,
   input  logic         ce,
   input  logic         rw,
   input  logic         aec,
   input  raster_x_t    raster_x,
   input  raster_line_t raster_line,
   input  reg_data_t    dbo,
   input  logic         irq,
   input  logic         ls245_dir,
   input  logic         vic_write_db,
   // 0 none, 1 dbo exact, 2 dbo against the beam line, 3 irq level
   input  logic [1:0]   chk_req,
   input  reg_data_t    chk_exp,
   output int           errors
);

   logic         synced;
   int           dot_cnt;
   int           start_wait;
   raster_x_t    exp_x;
   raster_line_t exp_line;
   raster_x_t    x_last;
   raster_line_t y_last;
   raster_line_t prev_line;
   logic         exp_dir;
   // tick within the phi period, 3 right after reset and 16 on the first high tick
   fine_ctr_t    fine_exp;
   logic         exp_wdb;

   initial errors = 0;

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("MISMATCH %s got %0h expected %0h", name, got, exp);
      errors++;
   endtask

   // line length and frame height per chip type
   always_comb begin
      case (chip)
         CHIP6567R8: begin
            x_last = 10'd519;
            y_last = 9'd262;
         end
         CHIP6567R56A: begin
            x_last = 10'd511;
            y_last = 9'd261;
         end
         default: begin
            x_last = 10'd503;
            y_last = 9'd311;
         end
      endcase
   end

   // all values are taken before the edge updates them
   always @(posedge clk_dot4x) begin
      if (rst) begin
         synced     = 1'b0;
         dot_cnt    = 0;
         start_wait = 0;
         fine_exp   = 5'd2;
      end else begin
         fine_exp = fine_exp + 5'd1;
         // transceiver drives the cpu side only on a cpu read
         exp_dir = (aec && !ce) ? !rw : 1'b1;
         if (ls245_dir !== exp_dir) begin
            report_mismatch("ls245_dir", 32'(ls245_dir), 32'(exp_dir));
         end
         // chip drives the data bus during a cpu read up to tick 23
         exp_wdb = aec && rw && !ce && (fine_exp <= 5'd23);
         if (vic_write_db !== exp_wdb) begin
            report_mismatch("vic_write_db", 32'(vic_write_db), 32'(exp_wdb));
         end
         if (!synced) begin
            // lock onto the first pixel step after reset
            if (raster_x == 10'd1) begin
               synced   = 1'b1;
               exp_x    = 10'd1;
               exp_line = 9'd0;
               dot_cnt  = 0;
            end else if (raster_x !== 10'd0) begin
               report_mismatch("raster_x", 32'(raster_x), 32'd0);
            end
            start_wait++;
            if (start_wait == 9) begin
               $display("raster_x did not start counting after reset");
               errors++;
            end
         end else begin
            // one pixel every 4 ticks
            dot_cnt++;
            if (dot_cnt == 4) begin
               dot_cnt = 0;
               if (exp_x == x_last) begin
                  exp_x = 10'd0;
                  if (exp_line == y_last) begin
                     exp_line = 9'd0;
                  end else begin
                     exp_line = exp_line + 9'd1;
                  end
               end else begin
                  exp_x = exp_x + 10'd1;
               end
            end
            if (raster_x !== exp_x) begin
               report_mismatch("raster_x", 32'(raster_x), 32'(exp_x));
               exp_x = raster_x;
            end
            if (raster_line !== exp_line) begin
               report_mismatch("raster_line", 32'(raster_line), 32'(exp_line));
               exp_line = raster_line;
            end
         end
         // checks handed over by the stimulus loop
         case (chk_req)
            2'd1: begin
               if (dbo !== chk_exp) begin
                  report_mismatch("dbo", 32'(dbo), 32'(chk_exp));
               end
            end
            2'd2: begin
               // read value lags the beam by up to one phi period
               prev_line = raster_line - 9'd1;
               if (dbo !== raster_line[7:0] && dbo !== prev_line[7:0]) begin
                  report_mismatch("dbo", 32'(dbo), 32'(raster_line[7:0]));
               end
            end
            2'd3: begin
               if (irq !== chk_exp[0]) begin
                  report_mismatch("irq", 32'(irq), 32'(chk_exp[0]));
               end
            end
            default: ;
         endcase
      end
   end

endmodule

// ==== testbench/vicii_properties.sv ====
`timescale 1ns/1ps

// phase and bus timing assertions, bound into vicii_core
module vicii_properties (
   input logic clk_dot4x,
   input logic rst,
   input logic clk_phi,
   input logic aec,
   input logic ce,
   input logic rw,
   input logic vic_write_db
);

   // clk_phi level seen on the previous tick
   logic       phi_q;
   // ticks clk_phi has held since its last edge
   logic [4:0] run_len;
   // first edge after reset seen
   logic       seen_edge;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_q     <= 1'b0;
         run_len   <= 5'd0;
         seen_edge <= 1'b0;
      end else begin
         phi_q <= clk_phi;
         if (clk_phi != phi_q) begin
            run_len   <= 5'd0;
            seen_edge <= 1'b1;
         end else begin
            run_len <= run_len + 5'd1;
         end
      end
   end

   // each phase is 16 ticks long
   phi_half_period: assert property (@(posedge clk_dot4x) disable iff (rst)
      (seen_edge && clk_phi != phi_q) |-> (run_len == 5'd15))
      else $error("clk_phi phase length is not 16 ticks");

   // bus ownership trails the phase clock by one tick
   aec_follows_phi: assert property (@(posedge clk_dot4x) disable iff (rst)
      aec == $past(clk_phi))
      else $error("aec is not clk_phi delayed by one tick");

   // chip only drives the data bus during a cpu read
   db_drive_rule: assert property (@(posedge clk_dot4x) disable iff (rst)
      vic_write_db |-> (aec && rw && !ce))
      else $error("vic_write_db high outside a cpu read");

endmodule

// ==== vicii_core.f ====
common/vicii_pkg.sv
common/phase_if.sv
hw/phase_gen.sv
hw/raster_counter.sv
hw/raster_irq.sv
hw/registers.sv
hw/vicii_core.sv
testbench/vicii_properties.sv
testbench/vicii_checker.sv
testbench/tb_vicii.sv
